// File: design/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // fetch here means the program is done
    localparam logic [XLEN-1:0] HALT_ADDR = 32'h400;

    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    // arithmetic funct3
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // branch funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_LW_SW = 3'b010; // word access only

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // sub, sra, srai

    typedef enum logic [4:0] {
        ALU_ADD  = 5'b00000,
        ALU_SUB  = 5'b00001,
        ALU_AND  = 5'b00010,
        ALU_OR   = 5'b00011,
        ALU_XOR  = 5'b00100,
        ALU_SLL  = 5'b00101,
        ALU_SRL  = 5'b00110,
        ALU_SRA  = 5'b00111,
        ALU_SLT  = 5'b01000,
        ALU_SLTU = 5'b01001,
        BR_BEQ   = 5'b01010,
        BR_BNE   = 5'b01011,
        BR_BLT   = 5'b01100,
        BR_BGE   = 5'b01101,
        BR_BLTU  = 5'b01110,
        BR_BGEU  = 5'b01111,
        ALU_JALR = 5'b10000
    } alu_op_e;

    typedef enum logic {OP1_RS1, OP1_PC} op1_sel_e;

    typedef enum logic [1:0] {OP2_RS2, OP2_IMM_I, OP2_IMM_S, OP2_IMM_J} op2_sel_e;

    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC} wb_sel_e;

endpackage

`default_nettype wire

// File: design/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
    input  logic [rv_core_pkg::XLEN-1:0]       inst_i,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] rs1_addr_o,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] rs2_addr_o,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] rd_addr_o,
    output logic [rv_core_pkg::XLEN-1:0]       imm_i_o,
    output logic [rv_core_pkg::XLEN-1:0]       imm_s_o,
    output logic [rv_core_pkg::XLEN-1:0]       imm_b_o,
    output logic [rv_core_pkg::XLEN-1:0]       imm_j_o,
    output rv_core_pkg::alu_op_e               alu_op_o,
    output rv_core_pkg::op1_sel_e              op1_sel_o,
    output rv_core_pkg::op2_sel_e              op2_sel_o,
    output logic                               mem_wen_o,
    output logic                               rf_wen_o,
    output logic                               jump_o,
    output rv_core_pkg::wb_sel_e               wb_sel_o
);

    import rv_core_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    // shared by OP and OP_IMM
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            F3_ADD_SUB: begin
                if (alt) op = ALU_SUB;
                else     op = ALU_ADD;
            end
            F3_SLL:  op = ALU_SLL;
            F3_SLT:  op = ALU_SLT;
            F3_SLTU: op = ALU_SLTU;
            F3_XOR:  op = ALU_XOR;
            F3_SRL_SRA: begin
                if (alt) op = ALU_SRA;
                else     op = ALU_SRL;
            end
            F3_OR:   op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode = opcode_e'(inst_i[6:0]);
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];
    assign rd_addr_o  = inst_i[11:7];

    assign imm_i_o = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s_o = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b_o = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                      inst_i[11:8], 1'b0};
    assign imm_j_o = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                      inst_i[30:21], 1'b0};

    always_comb begin
        // anything unmatched stays a no-op
        alu_op_o  = ALU_ADD;
        op1_sel_o = OP1_RS1;
        op2_sel_o = OP2_RS2;
        mem_wen_o = 1'b0;
        rf_wen_o  = 1'b0;
        jump_o    = 1'b0;
        wb_sel_o  = WB_ALU;

        case (opcode)
            OPC_LOAD: begin
                if (funct3 == F3_LW_SW) begin
                    op2_sel_o = OP2_IMM_I;
                    rf_wen_o  = 1'b1;
                    wb_sel_o  = WB_MEM;
                end
            end
            OPC_STORE: begin
                if (funct3 == F3_LW_SW) begin
                    op2_sel_o = OP2_IMM_S;
                    mem_wen_o = 1'b1;
                end
            end
            OPC_OP: begin
                if (funct7 == F7_BASE ||
                    (funct7 == F7_ALT && (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA))) begin
                    alu_op_o = arith_op(funct3, funct7 == F7_ALT);
                    rf_wen_o = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                // only the shifts carry a funct7
                if ((funct3 != F3_SLL && funct3 != F3_SRL_SRA) || funct7 == F7_BASE ||
                    (funct3 == F3_SRL_SRA && funct7 == F7_ALT)) begin
                    alu_op_o  = arith_op(funct3, funct3 == F3_SRL_SRA && funct7 == F7_ALT);
                    op2_sel_o = OP2_IMM_I;
                    rf_wen_o  = 1'b1;
                end
            end
            OPC_BRANCH: begin
                case (funct3)
                    F3_BEQ:  alu_op_o = BR_BEQ;
                    F3_BNE:  alu_op_o = BR_BNE;
                    F3_BLT:  alu_op_o = BR_BLT;
                    F3_BGE:  alu_op_o = BR_BGE;
                    F3_BLTU: alu_op_o = BR_BLTU;
                    F3_BGEU: alu_op_o = BR_BGEU;
                    default: alu_op_o = ALU_ADD; // 010/011 reserved
                endcase
            end
            OPC_JAL: begin
                op1_sel_o = OP1_PC;
                op2_sel_o = OP2_IMM_J;
                rf_wen_o  = 1'b1;
                jump_o    = 1'b1;
                wb_sel_o  = WB_PC;
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    alu_op_o  = ALU_JALR;
                    op2_sel_o = OP2_IMM_I;
                    rf_wen_o  = 1'b1;
                    jump_o    = 1'b1;
                    wb_sel_o  = WB_PC;
                end
            end
            default: ;
        endcase

        // a store never writes back
        assert (!(mem_wen_o && rf_wen_o))
            else $error("decode: store with register write, inst %h", inst_i);
    end

endmodule

`default_nettype wire

// File: design/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] rd_addr_i,
    input  logic [rv_core_pkg::XLEN-1:0]       rd_data_i,
    input  logic                               rd_wen_i,
    output logic [rv_core_pkg::XLEN-1:0]       rs1_data_o,
    output logic [rv_core_pkg::XLEN-1:0]       rs2_data_o
);

    import rv_core_pkg::*;

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_wen_i && rd_addr_i != '0) begin // x0 writes dropped
            regs[rd_addr_i] <= rd_data_i;
        end
    end

    // x0 reads as zero regardless of contents
    always_comb begin
        if (rs1_addr_i == '0) rs1_data_o = '0;
        else                  rs1_data_o = regs[rs1_addr_i];
    end

    always_comb begin
        if (rs2_addr_i == '0) rs2_data_o = '0;
        else                  rs2_data_o = regs[rs2_addr_i];
    end

endmodule

`default_nettype wire

// File: design/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
    input  logic [rv_core_pkg::XLEN-1:0] pc_i,
    input  logic [rv_core_pkg::XLEN-1:0] rs1_data_i,
    input  logic [rv_core_pkg::XLEN-1:0] rs2_data_i,
    input  logic [rv_core_pkg::XLEN-1:0] imm_i_i,
    input  logic [rv_core_pkg::XLEN-1:0] imm_s_i,
    input  logic [rv_core_pkg::XLEN-1:0] imm_b_i,
    input  logic [rv_core_pkg::XLEN-1:0] imm_j_i,
    input  rv_core_pkg::alu_op_e         alu_op_i,
    input  rv_core_pkg::op1_sel_e        op1_sel_i,
    input  rv_core_pkg::op2_sel_e        op2_sel_i,
    output logic [rv_core_pkg::XLEN-1:0] alu_out_o,
    output logic                         branch_taken_o,
    output logic [rv_core_pkg::XLEN-1:0] branch_target_o
);

    import rv_core_pkg::*;

    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic [4:0]      shamt;
    logic            eq;
    logic            lt;
    logic            ltu;

    assign op1 = (op1_sel_i == OP1_PC) ? pc_i : rs1_data_i;

    always_comb begin
        case (op2_sel_i)
            OP2_IMM_I: op2 = imm_i_i;
            OP2_IMM_S: op2 = imm_s_i;
            OP2_IMM_J: op2 = imm_j_i;
            default:   op2 = rs2_data_i;
        endcase
    end

    assign shamt = op2[4:0];
    assign eq    = (op1 == op2);
    assign lt    = ($signed(op1) < $signed(op2));
    assign ltu   = (op1 < op2);

    always_comb begin
        case (alu_op_i)
            ALU_ADD:  alu_out_o = op1 + op2;
            ALU_SUB:  alu_out_o = op1 - op2;
            ALU_AND:  alu_out_o = op1 & op2;
            ALU_OR:   alu_out_o = op1 | op2;
            ALU_XOR:  alu_out_o = op1 ^ op2;
            ALU_SLL:  alu_out_o = op1 << shamt;
            ALU_SRL:  alu_out_o = op1 >> shamt;
            ALU_SRA:  alu_out_o = $signed(op1) >>> shamt;
            ALU_SLT:  alu_out_o = {{(XLEN-1){1'b0}}, lt};
            ALU_SLTU: alu_out_o = {{(XLEN-1){1'b0}}, ltu};
            ALU_JALR: alu_out_o = (op1 + op2) & ~32'd1; // target bit 0 cleared
            default:  alu_out_o = '0;
        endcase
    end

    always_comb begin
        case (alu_op_i)
            BR_BEQ:  branch_taken_o = eq;
            BR_BNE:  branch_taken_o = !eq;
            BR_BLT:  branch_taken_o = lt;
            BR_BGE:  branch_taken_o = !lt;
            BR_BLTU: branch_taken_o = ltu;
            BR_BGEU: branch_taken_o = !ltu;
            default: branch_taken_o = 1'b0;
        endcase
        assert (!branch_taken_o || alu_op_i inside {[BR_BEQ:BR_BGEU]})
            else $error("execute: branch taken under op %s", alu_op_i.name());
    end

    assign branch_target_o = pc_i + imm_b_i;

endmodule

`default_nettype wire

// File: design/rv_result.sv
`timescale 1ns/1ps
`default_nettype none

module rv_result (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [rv_core_pkg::XLEN-1:0] alu_out_i,
    input  logic [rv_core_pkg::XLEN-1:0] dmem_rdata_i,
    input  rv_core_pkg::wb_sel_e         wb_sel_i,
    input  logic                         rf_wen_i,
    input  logic                         mem_wen_i,
    input  logic                         jump_i,
    input  logic                         branch_taken_i,
    input  logic [rv_core_pkg::XLEN-1:0] branch_target_i,
    output logic [rv_core_pkg::XLEN-1:0] pc_o,
    output logic [rv_core_pkg::XLEN-1:0] rd_data_o,
    output logic                         rd_wen_o,
    output logic                         dmem_wen_o,
    output logic                         exit_o
);

    import rv_core_pkg::*;

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] pc_next;
    logic            halted;

    assign pc_plus4 = pc_q + 32'd4;
    assign halted   = (pc_q == HALT_ADDR);

    always_comb begin
        case (wb_sel_i)
            WB_MEM:  rd_data_o = dmem_rdata_i;
            WB_PC:   rd_data_o = pc_plus4; // link value
            default: rd_data_o = alu_out_i;
        endcase
    end

    always_comb begin
        if (halted)              pc_next = pc_q;
        else if (branch_taken_i) pc_next = branch_target_i;
        else if (jump_i)         pc_next = alu_out_i;
        else                     pc_next = pc_plus4;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) pc_q <= '0;
        else        pc_q <= pc_next;
    end

    assign pc_o       = pc_q;
    assign exit_o     = halted;
    assign rd_wen_o   = rf_wen_i && !halted;
    assign dmem_wen_o = mem_wen_i && !halted && rst_n; // no stores while in reset

    pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc_o[1:0] == 2'b00)
        else $error("result: misaligned pc %h", pc_o);

endmodule

`default_nettype wire

// File: design/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core (
    input  logic                         clk,
    input  logic                         rst_n,
    output logic [rv_core_pkg::XLEN-1:0] imem_addr_o,
    input  logic [rv_core_pkg::XLEN-1:0] imem_inst_i,
    output logic [rv_core_pkg::XLEN-1:0] dmem_addr_o,
    input  logic [rv_core_pkg::XLEN-1:0] dmem_rdata_i,
    output logic                         dmem_wen_o,
    output logic [rv_core_pkg::XLEN-1:0] dmem_wdata_o,
    output logic                         exit_o
);

    import rv_core_pkg::*;

    logic [XLEN-1:0]       pc;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [XLEN-1:0]       imm_i;
    logic [XLEN-1:0]       imm_s;
    logic [XLEN-1:0]       imm_b;
    logic [XLEN-1:0]       imm_j;
    alu_op_e               alu_op;
    op1_sel_e              op1_sel;
    op2_sel_e              op2_sel;
    wb_sel_e               wb_sel;
    logic                  mem_wen;
    logic                  rf_wen;
    logic                  jump;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [XLEN-1:0]       alu_out;
    logic                  branch_taken;
    logic [XLEN-1:0]       branch_target;
    logic [XLEN-1:0]       rd_data;
    logic                  rd_wen;

    assign imem_addr_o  = pc;
    assign dmem_addr_o  = alu_out;  // effective address for lw/sw
    assign dmem_wdata_o = rs2_data;

    rv_decode rv_decode_inst (
        .inst_i(imem_inst_i), .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
        .rd_addr_o(rd_addr), .imm_i_o(imm_i), .imm_s_o(imm_s), .imm_b_o(imm_b),
        .imm_j_o(imm_j), .alu_op_o(alu_op), .op1_sel_o(op1_sel), .op2_sel_o(op2_sel),
        .mem_wen_o(mem_wen), .rf_wen_o(rf_wen), .jump_o(jump), .wb_sel_o(wb_sel)
    );

    rv_regfile rv_regfile_inst (
        .clk(clk), .rst_n(rst_n), .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
        .rd_addr_i(rd_addr), .rd_data_i(rd_data), .rd_wen_i(rd_wen),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
    );

    rv_execute rv_execute_inst (
        .pc_i(pc), .rs1_data_i(rs1_data), .rs2_data_i(rs2_data), .imm_i_i(imm_i),
        .imm_s_i(imm_s), .imm_b_i(imm_b), .imm_j_i(imm_j), .alu_op_i(alu_op),
        .op1_sel_i(op1_sel), .op2_sel_i(op2_sel), .alu_out_o(alu_out),
        .branch_taken_o(branch_taken), .branch_target_o(branch_target)
    );

    rv_result rv_result_inst (
        .clk(clk), .rst_n(rst_n), .alu_out_i(alu_out), .dmem_rdata_i(dmem_rdata_i),
        .wb_sel_i(wb_sel), .rf_wen_i(rf_wen), .mem_wen_i(mem_wen), .jump_i(jump),
        .branch_taken_i(branch_taken), .branch_target_i(branch_target), .pc_o(pc),
        .rd_data_o(rd_data), .rd_wen_o(rd_wen), .dmem_wen_o(dmem_wen_o), .exit_o(exit_o)
    );

endmodule

`default_nettype wire

// File: testbench/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

    import rv_core_pkg::*;

    localparam int NUM_TESTS  = 5;
    localparam int IMEM_WORDS = 512;
    localparam int DMEM_WORDS = 256;

    logic            clk;
    logic            rst_n;
    logic [XLEN-1:0] imem_addr;
    logic [XLEN-1:0] imem_inst;
    logic [XLEN-1:0] dmem_addr;
    logic [XLEN-1:0] dmem_rdata;
    logic [XLEN-1:0] dmem_wdata;
    logic            dmem_wen;
    logic            exit_flag;

    logic [XLEN-1:0] imem [IMEM_WORDS];
    logic [XLEN-1:0] dmem [DMEM_WORDS];
    logic [XLEN-1:0] st_addr [$];   // every store seen on the bus
    logic [XLEN-1:0] st_data [$];
    logic [XLEN-1:0] exp_addr [$];  // stores the current program should make
    logic [XLEN-1:0] exp_data [$];
    logic [XLEN-1:0] pc_asm;        // next free program address
    int              first_store;
    integer          seed;

    rv_core rv_core_inst (
        .clk(clk), .rst_n(rst_n), .imem_addr_o(imem_addr), .imem_inst_i(imem_inst),
        .dmem_addr_o(dmem_addr), .dmem_rdata_i(dmem_rdata), .dmem_wen_o(dmem_wen),
        .dmem_wdata_o(dmem_wdata), .exit_o(exit_flag)
    );

    // memories answer combinationally
    assign imem_inst  = imem[imem_addr[10:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    always @(posedge clk) begin
        if (dmem_wen) begin
            st_addr.push_back(dmem_addr);
            st_data.push_back(dmem_wdata);
        end
    end

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (NUM_TESTS * 2000) @(posedge clk);
        $display("watchdog: core did not reach the halt address in time");
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input opcode_e opc, input logic [11:0] imm,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, F3_LW_SW, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // reference results straight from the ISA manual
    function automatic logic [31:0] arith_ref(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] x, input logic [31:0] y);
        logic [31:0] r;
        case (f3)
            F3_ADD_SUB: r = alt ? x - y : x + y;
            F3_SLL:     r = x << y[4:0];
            F3_SLT:     r = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            F3_SLTU:    r = (x < y) ? 32'd1 : 32'd0;
            F3_XOR:     r = x ^ y;
            F3_SRL_SRA: begin
                if (alt) r = $signed(x) >>> y[4:0];
                else     r = x >> y[4:0];
            end
            F3_OR:      r = x | y;
            default:    r = x & y;
        endcase
        return r;
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] x,
                                        input logic [31:0] y);
        case (f3)
            F3_BEQ:  return x == y;
            F3_BNE:  return x != y;
            F3_BLT:  return $signed(x) < $signed(y);
            F3_BGE:  return $signed(x) >= $signed(y);
            F3_BLTU: return x < y;
            default: return x >= y;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input string what,
                                   input logic [31:0] expected, input logic [31:0] actual);
        $display("Fail %s %s expected %h actual %h", name, what, expected, actual);
        $display("TEST FAILED");
        $fatal(1, "%s: wrong value", name);
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "check failed");
    endtask

    task automatic clear_memories();
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = i_type(OPC_OP_IMM, 12'd0, 5'd0, F3_ADD_SUB, 5'd0); // nop
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = 32'hDA7A0000 | 32'(i << 2);
        end
        exp_addr.delete();
        exp_data.delete();
        pc_asm = '0;
    endtask

    task automatic emit(input logic [31:0] inst);
        imem[pc_asm[10:2]] = inst;
        pc_asm = pc_asm + 32'd4;
    endtask

    task automatic set_word(input logic [31:0] addr, input logic [31:0] value);
        dmem[addr[9:2]] = value;
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] value);
        exp_addr.push_back(addr);
        exp_data.push_back(value);
    endtask

    // sw x3 into a result slot based at x10
    task automatic store_and_expect(input int slot, input logic [31:0] value);
        emit(s_type(12'(slot * 4), 5'd3, 5'd10));
        expect_store(32'h300 + 32'(slot * 4), value);
    endtask

    task automatic halt_jump();
        emit(j_type(5'd0, 21'(HALT_ADDR - pc_asm)));
    endtask

    task automatic run_program();
        @(posedge clk);
        #1 rst_n = 1'b0;
        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;
        first_store = st_addr.size();
        @(negedge clk);
        while (!exit_flag) @(negedge clk);
    endtask

    task automatic compare_stores(input string name);
        int n;
        n = st_addr.size() - first_store;
        assert (n == exp_addr.size())
            else report_mismatch(name, "store count", 32'(exp_addr.size()), 32'(n));
        foreach (exp_addr[i]) begin
            assert (st_addr[first_store + i] == exp_addr[i])
                else report_mismatch(name, $sformatf("store %0d addr", i), exp_addr[i],
                                     st_addr[first_store + i]);
            assert (st_data[first_store + i] == exp_data[i])
                else report_mismatch(name, $sformatf("store %0d data", i), exp_data[i],
                                     st_data[first_store + i]);
        end
    endtask

    task automatic arith_ops();
        logic [31:0] a;
        logic [31:0] b;
        logic [11:0] imm;
        logic [2:0]  f3;
        logic        alt;
        int          slot;
        clear_memories();
        a = $random(seed);
        b = $random(seed);
        set_word(32'h200, a);
        set_word(32'h204, b);
        emit(i_type(OPC_LOAD, 12'h200, 5'd0, F3_LW_SW, 5'd1));
        emit(i_type(OPC_LOAD, 12'h204, 5'd0, F3_LW_SW, 5'd2));
        emit(i_type(OPC_OP_IMM, 12'h300, 5'd0, F3_ADD_SUB, 5'd10));
        slot = 0;
        for (int k = 0; k < 10; k++) begin // all eight funct3 plus sub and sra
            f3  = (k < 8) ? 3'(k) : ((k == 8) ? F3_ADD_SUB : F3_SRL_SRA);
            alt = (k >= 8);
            emit(r_type(alt ? F7_ALT : F7_BASE, 5'd2, 5'd1, f3, 5'd3));
            store_and_expect(slot, arith_ref(f3, alt, a, b));
            slot++;
        end
        for (int k = 0; k < 9; k++) begin
            f3  = (k < 8) ? 3'(k) : F3_SRL_SRA;
            alt = (k == 8);
            imm = 12'($random(seed));
            if (f3 == F3_SLL || f3 == F3_SRL_SRA) begin
                imm = {alt ? F7_ALT : F7_BASE, imm[4:0]};
            end
            emit(i_type(OPC_OP_IMM, imm, 5'd1, f3, 5'd3));
            store_and_expect(slot, arith_ref(f3, alt, a, sext12(imm)));
            slot++;
        end
        halt_jump();
        run_program();
        compare_stores("arith_ops");
    endtask

    task automatic mem_copy();
        logic [31:0] word;
        logic [11:0] src_off;
        logic [11:0] dst_off;
        clear_memories();
        emit(i_type(OPC_OP_IMM, 12'h200, 5'd0, F3_ADD_SUB, 5'd5));
        emit(i_type(OPC_OP_IMM, 12'h300, 5'd0, F3_ADD_SUB, 5'd6));
        for (int k = 0; k < 4; k++) begin
            src_off = 12'(32 * k - 64 + 4 * ($random(seed) & 7)); // both signs
            dst_off = (k % 2 == 1) ? 12'(-(8 + 4 * k)) : 12'(8 + 4 * k);
            word    = $random(seed);
            set_word(32'h200 + sext12(src_off), word);
            emit(i_type(OPC_LOAD, src_off, 5'd5, F3_LW_SW, 5'd7));
            emit(s_type(dst_off, 5'd7, 5'd6));
            expect_store(32'h300 + sext12(dst_off), word);
        end
        halt_jump();
        run_program();
        compare_stores("mem_copy");
    endtask

    task automatic branch_paths();
        logic [31:0] pair_a [4];
        logic [31:0] pair_b [4];
        logic [2:0]  br_f3 [6];
        logic [11:0] marker;
        int          slot;
        pair_a = '{32'd5, 32'hFFFFFFFD, 32'h80000000, 32'd3};
        pair_b = '{32'd5, 32'd2, 32'd1, 32'h90000000};
        br_f3  = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
        clear_memories();
        emit(i_type(OPC_OP_IMM, 12'h300, 5'd0, F3_ADD_SUB, 5'd10));
        slot = 0;
        for (int p = 0; p < 4; p++) begin
            set_word(32'h200 + 32'(8 * p), pair_a[p]);
            set_word(32'h204 + 32'(8 * p), pair_b[p]);
            emit(i_type(OPC_LOAD, 12'(32'h200 + 8 * p), 5'd0, F3_LW_SW, 5'd1));
            emit(i_type(OPC_LOAD, 12'(32'h204 + 8 * p), 5'd0, F3_LW_SW, 5'd2));
            for (int k = 0; k < 6; k++) begin
                marker = 12'(16 * slot);
                emit(b_type(br_f3[k], 5'd1, 5'd2, 13'd12));
                emit(i_type(OPC_OP_IMM, marker + 12'd2, 5'd0, F3_ADD_SUB, 5'd3));
                emit(j_type(5'd0, 21'd8)); // skip the taken path
                emit(i_type(OPC_OP_IMM, marker + 12'd1, 5'd0, F3_ADD_SUB, 5'd3));
                if (branch_ref(br_f3[k], pair_a[p], pair_b[p])) begin
                    store_and_expect(slot, {20'd0, marker + 12'd1});
                end else begin
                    store_and_expect(slot, {20'd0, marker + 12'd2});
                end
                slot++;
            end
        end
        halt_jump();
        run_program();
        compare_stores("branch_paths");
    endtask

    task automatic jump_links();
        logic [31:0] jal_pc;
        logic [31:0] jalr_pc;
        clear_memories();
        emit(i_type(OPC_OP_IMM, 12'h300, 5'd0, F3_ADD_SUB, 5'd10));
        jal_pc = pc_asm;
        emit(j_type(5'd1, 21'd12));
        emit(i_type(OPC_OP_IMM, 12'h7FF, 5'd0, F3_ADD_SUB, 5'd1)); // clobbers link if run
        emit(i_type(OPC_OP_IMM, 12'h7FF, 5'd0, F3_ADD_SUB, 5'd1));
        emit(s_type(12'd0, 5'd1, 5'd10));
        expect_store(32'h300, jal_pc + 32'd4);
        // rs1 + 5 lands one byte past the store below
        jalr_pc = pc_asm + 32'd4;
        emit(i_type(OPC_OP_IMM, 12'(jalr_pc + 32'd16), 5'd0, F3_ADD_SUB, 5'd5));
        emit(i_type(OPC_JALR, 12'd5, 5'd5, 3'b000, 5'd2));
        repeat (4) emit(i_type(OPC_OP_IMM, 12'h7FF, 5'd0, F3_ADD_SUB, 5'd2));
        emit(s_type(12'd4, 5'd2, 5'd10));
        expect_store(32'h304, jalr_pc + 32'd4);
        halt_jump();
        run_program();
        compare_stores("jump_links");
    endtask

    task automatic zero_and_halt();
        int count;
        clear_memories();
        emit(i_type(OPC_OP_IMM, 12'h123, 5'd0, F3_ADD_SUB, 5'd0));
        emit(i_type(OPC_OP_IMM, 12'd7, 5'd0, F3_ADD_SUB, 5'd1));
        emit(r_type(F7_BASE, 5'd1, 5'd1, F3_ADD_SUB, 5'd0));
        emit(s_type(12'h300, 5'd0, 5'd0));
        expect_store(32'h300, 32'd0);
        halt_jump();
        imem[HALT_ADDR[10:2]] = s_type(12'h304, 5'd1, 5'd0); // parked store, never commits
        run_program();
        compare_stores("zero_and_halt");
        assert (imem_addr == HALT_ADDR)
            else report_mismatch("zero_and_halt", "halt pc", HALT_ADDR, imem_addr);
        count = st_addr.size();
        repeat (10) begin
            @(negedge clk);
            assert (exit_flag && imem_addr == HALT_ADDR)
                else report_mismatch("zero_and_halt", "parked pc", HALT_ADDR, imem_addr);
            assert (st_addr.size() == count)
                else report_failure("zero_and_halt: a store happened after the core halted");
        end
    endtask

    initial begin
        seed        = 46;
        rst_n       = 1'b0;
        pc_asm      = '0;
        first_store = 0;
        arith_ops();
        mem_copy();
        branch_paths();
        jump_links();
        zero_and_halt();
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
design/rv_core_pkg.sv
design/rv_decode.sv
design/rv_regfile.sv
design/rv_execute.sv
design/rv_result.sv
design/rv_core.sv
testbench/rv_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= rv_core_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
